//--- src/coreDefs.sv
package coreDefs;

  // Widths fixed by the ISA
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // Immediate formats handled by immGen
  typedef enum logic [1:0] {
    immI = 2'b00,
    immS = 2'b01,
    immU = 2'b10,
    immJ = 2'b11
  } immSel_e;

  // ALU operations
  typedef enum logic [1:0] {
    aluAdd     = 2'b00,
    aluPassB   = 2'b01,
    aluAddClr0 = 2'b10
  } aluOp_e;

  // Writeback sources
  typedef enum logic [1:0] {
    wbMem = 2'b00,
    wbAlu = 2'b01,
    wbPc4 = 2'b10
  } wbSel_e;

  localparam word_t resetPc = 32'h8000_0000;

  // Major opcodes of the kept instructions
  localparam opcode_t opLui    = 7'b0110111;
  localparam opcode_t opAuipc  = 7'b0010111;
  localparam opcode_t opJal    = 7'b1101111;
  localparam opcode_t opJalr   = 7'b1100111;
  localparam opcode_t opLoad   = 7'b0000011;
  localparam opcode_t opStore  = 7'b0100011;
  localparam opcode_t opImm    = 7'b0010011;
  localparam opcode_t opReg    = 7'b0110011;
  localparam opcode_t opSystem = 7'b1110011;

  // funct3 for add, addi and jalr
  localparam funct3_t funct3Add  = 3'b000;
  // funct3 for word loads and stores
  localparam funct3_t funct3Word = 3'b010;

  // Only system word that is accepted
  localparam word_t ebreakWord = 32'h0010_0073;

endpackage

//--- src/ctrlIf.sv
interface ctrlIf import coreDefs::*; ();

  logic    regWrite;
  logic    memWriteReq;
  logic    ebreak;
  logic    pcSel;
  logic    aSel;
  logic    bSel;
  immSel_e immSel;
  aluOp_e  aluOp;
  wbSel_e  wbSel;

  modport decoder (
    output regWrite, memWriteReq, ebreak, pcSel, aSel, bSel,
    output immSel, aluOp, wbSel
  );

  // Operand, ALU and mux controls only
  modport datapath (
    input aSel, bSel, aluOp, pcSel, wbSel
  );

endinterface

//--- src/instDecoder.sv
module instDecoder import coreDefs::*; (
  input  word_t          inst,
  ctrlIf.decoder         ctrl,
  output logic           illegal
);

  opcode_t opcode;
  funct3_t funct3;
  logic    funct7Zero;

  assign opcode     = inst[6:0];
  assign funct3     = inst[14:12];
  // add is the only R-type kept, so funct7 must be all zero
  assign funct7Zero = (inst[31:25] == 7'b0);

  always_comb begin
    // Everything low unless a kept instruction matches
    ctrl.regWrite    = 1'b0;
    ctrl.memWriteReq = 1'b0;
    ctrl.ebreak      = 1'b0;
    ctrl.pcSel       = 1'b0;
    ctrl.aSel        = 1'b0;
    ctrl.bSel        = 1'b0;
    ctrl.immSel      = immI;
    ctrl.aluOp       = aluAdd;
    ctrl.wbSel       = wbMem;
    illegal          = 1'b0;

    case (opcode)
      opLui: begin
        ctrl.regWrite = 1'b1;
        ctrl.bSel     = 1'b1;
        ctrl.immSel   = immU;
        ctrl.aluOp    = aluPassB;
        ctrl.wbSel    = wbAlu;
      end
      opAuipc: begin
        ctrl.regWrite = 1'b1;
        ctrl.aSel     = 1'b1;
        ctrl.bSel     = 1'b1;
        ctrl.immSel   = immU;
        ctrl.wbSel    = wbAlu;
      end
      opImm: begin
        if (funct3 == funct3Add) begin
          ctrl.regWrite = 1'b1;
          ctrl.bSel     = 1'b1;
          ctrl.wbSel    = wbAlu;
        end else begin
          illegal = 1'b1;
        end
      end
      opReg: begin
        if (funct3 == funct3Add && funct7Zero) begin
          ctrl.regWrite = 1'b1;
          ctrl.wbSel    = wbAlu;
        end else begin
          illegal = 1'b1;
        end
      end
      opJal: begin
        // Target is pc + immJ and link is pc + 4
        ctrl.regWrite = 1'b1;
        ctrl.pcSel    = 1'b1;
        ctrl.aSel     = 1'b1;
        ctrl.bSel     = 1'b1;
        ctrl.immSel   = immJ;
        ctrl.wbSel    = wbPc4;
      end
      opJalr: begin
        if (funct3 == funct3Add) begin
          ctrl.regWrite = 1'b1;
          ctrl.pcSel    = 1'b1;
          ctrl.bSel     = 1'b1;
          ctrl.aluOp    = aluAddClr0;
          ctrl.wbSel    = wbPc4;
        end else begin
          illegal = 1'b1;
        end
      end
      opLoad: begin
        if (funct3 == funct3Word) begin
          ctrl.regWrite = 1'b1;
          ctrl.bSel     = 1'b1;
          ctrl.wbSel    = wbMem;
        end else begin
          illegal = 1'b1;
        end
      end
      opStore: begin
        if (funct3 == funct3Word) begin
          ctrl.memWriteReq = 1'b1;
          ctrl.bSel        = 1'b1;
          ctrl.immSel      = immS;
        end else begin
          illegal = 1'b1;
        end
      end
      opSystem: begin
        if (inst == ebreakWord) ctrl.ebreak = 1'b1;
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- src/immGen.sv
module immGen import coreDefs::*; (
  input  logic [31:7] instHigh,
  input  immSel_e     immSel,
  output word_t       imm
);

  logic signBit;

  assign signBit = instHigh[31];

  always_comb begin
    unique case (immSel)
      immI: begin
        imm = {{20{signBit}}, instHigh[31:20]};
      end
      immS: begin
        // Split field, upper part sits where funct7 would be
        imm = {{20{signBit}}, instHigh[31:25], instHigh[11:7]};
      end
      immU: begin
        imm = {instHigh[31:12], 12'b0};
      end
      immJ: begin
        // Scrambled J layout, bit 0 is always zero
        imm = {{12{signBit}}, instHigh[19:12], instHigh[20], instHigh[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- src/registerFile.sv
module registerFile import coreDefs::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     wen,
  input  regAddr_t waddr,
  input  word_t    wdata,
  input  regAddr_t raddr1,
  input  regAddr_t raddr2,
  output word_t    rdata1,
  output word_t    rdata2
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      // x0 is never written so it keeps its reset value of zero
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous reads
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // rd slice from the top must be clean whenever a write happens
  writeAddrKnown: assert property (
    @(posedge clk) disable iff (reset)
      wen |-> !$isunknown(waddr)
  ) else $error("Register write with unknown address");

endmodule

//--- src/executeUnit.sv
module executeUnit import coreDefs::*; (
  ctrlIf.datapath  ctrl,
  input  word_t    pc,
  input  word_t    rs1Data,
  input  word_t    rs2Data,
  input  word_t    imm,
  input  word_t    memDataR,
  output word_t    aluOut,
  output word_t    nextPc,
  output word_t    wbData
);

  word_t opA;
  word_t opB;
  word_t sum;
  word_t pcPlus4;

  assign opA     = ctrl.aSel ? pc : rs1Data;
  assign opB     = ctrl.bSel ? imm : rs2Data;
  assign sum     = opA + opB;
  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    unique case (ctrl.aluOp)
      aluAdd:     aluOut = sum;
      aluPassB:   aluOut = opB;
      aluAddClr0: aluOut = {sum[31:1], 1'b0};
      default:    aluOut = sum;
    endcase
  end

  // Jumps take the ALU result, everything else falls through
  assign nextPc = ctrl.pcSel ? aluOut : pcPlus4;

  always_comb begin
    unique case (ctrl.wbSel)
      wbMem:   wbData = memDataR;
      wbAlu:   wbData = aluOut;
      wbPc4:   wbData = pcPlus4;
      default: wbData = aluOut;
    endcase
  end

endmodule

//--- src/pcUnit.sv
module pcUnit import coreDefs::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t nextPc,
  input  logic  ebreak,
  output word_t pc,
  output logic  halt
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= resetPc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ebreak) begin
        // Stop here and keep pointing at the ebreak
        halt <= 1'b1;
      end else begin
        pc <= nextPc;
      end
    end
  end

  // Fetch is word based, so any jump target must stay aligned
  pcAligned: assert property (
    @(posedge clk) disable iff (reset)
      pc[1:0] == 2'b00
  ) else $error("Misaligned pc %h", pc);

endmodule

//--- src/rvCore.sv
module rvCore import coreDefs::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t inst,
  input  word_t memDataR,
  output word_t pc,
  output word_t memAddr,
  output word_t memDataW,
  output logic  memWrite,
  output logic  halt,
  output logic  illegal
);

  regAddr_t rs1;
  regAddr_t rs2;
  regAddr_t rd;
  word_t    rs1Data;
  word_t    rs2Data;
  word_t    imm;
  word_t    aluOut;
  word_t    nextPc;
  word_t    wbData;
  logic     regWen;

  ctrlIf ctrl ();

  // Register fields
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  instDecoder decoder (
    .inst    (inst),
    .ctrl    (ctrl),
    .illegal (illegal)
  );

  immGen immUnit (
    .instHigh (inst[31:7]),
    .immSel   (ctrl.immSel),
    .imm      (imm)
  );

  // No state may change after ebreak or while in reset
  assign regWen   = ctrl.regWrite && !halt && !reset;
  assign memWrite = ctrl.memWriteReq && !halt && !reset;

  registerFile regFile (
    .clk    (clk),
    .reset  (reset),
    .wen    (regWen),
    .waddr  (rd),
    .wdata  (wbData),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1Data),
    .rdata2 (rs2Data)
  );

  executeUnit execute (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .imm      (imm),
    .memDataR (memDataR),
    .aluOut   (aluOut),
    .nextPc   (nextPc),
    .wbData   (wbData)
  );

  // Loads and stores share the ALU address
  assign memAddr  = aluOut;
  assign memDataW = rs2Data;

  pcUnit pcReg (
    .clk    (clk),
    .reset  (reset),
    .nextPc (nextPc),
    .ebreak (ctrl.ebreak),
    .pc     (pc),
    .halt   (halt)
  );

endmodule

//--- sim/clockGen.sv
module clockGen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int halfPeriod  = 10;
  localparam int resetCycles = 16;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // Power-on reset, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- sim/coreTb.sv
module coreTb import coreDefs::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int periodNs       = 20;
  localparam int resetCycles    = 16;
  localparam int runBudget      = 30;
  localparam int testBudget     = 45;
  localparam int watchdogCycles = resetCycles + 6 * testBudget;
  localparam int memWords       = 256;
  localparam int dataIdx        = 64;

  logic  clk;
  logic  powerOnReset;
  logic  testReset;
  logic  reset;
  word_t inst;
  word_t memDataR;
  word_t pc;
  word_t memAddr;
  word_t memDataW;
  logic  memWrite;
  logic  halt;
  logic  illegal;

  word_t mem [memWords];
  word_t prog [$];
  word_t dataWord;
  word_t storeAddr [$];
  word_t storeData [$];
  word_t expAddr [$];
  word_t expData [$];
  word_t pcTrace [$];
  int    seed;
  int    errorCount;
  int    checkCount;

  clockGen clocks (.clk(clk), .reset(powerOnReset));

  assign reset = powerOnReset || testReset;

  rvCore DUT (.*);

  // Shared instruction and data memory word addressed from resetPc
  assign inst     = mem[pc[9:2]];
  assign memDataR = mem[memAddr[9:2]];

  // Store log and pc of every executed instruction
  always @(posedge clk) begin
    if (!reset && memWrite) begin
      storeAddr.push_back(memAddr);
      storeData.push_back(memDataW);
    end
    if (!reset && !halt) begin
      pcTrace.push_back(pc);
    end
  end

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t encI(input opcode_t op, input regAddr_t rd, input regAddr_t rs1,
                                 input logic [11:0] imm);
    return {imm, rs1, (op == opLoad) ? funct3Word : funct3Add, rd, op};
  endfunction

  function automatic word_t encS(input regAddr_t rs2, input regAddr_t rs1,
                                 input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, funct3Word, imm[4:0], opStore};
  endfunction

  function automatic word_t encJal(input regAddr_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    checkCount++;
    assert (actual === expected)
      else begin
        errorCount++;
        $display("Error: %s expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic compareQueue(input string name, input word_t expected [$],
                              input word_t actual [$]);
    checkCount++;
    assert (actual.size() == expected.size())
      else begin
        errorCount++;
        $display("Wrong number of %s entries, expected %0d but saw %0d",
                 name, expected.size(), actual.size());
      end
    for (int i = 0; i < expected.size() && i < actual.size(); i++) begin
      checkValue(name, expected[i], actual[i]);
    end
  endtask

  task automatic compareStores();
    compareQueue("memAddr", expAddr, storeAddr);
    compareQueue("memDataW", expData, storeData);
    expAddr.delete();
    expData.delete();
  endtask

  // Program from index 0 with one data word and ebreak everywhere else
  task automatic loadMemory();
    @(posedge clk);
    for (int i = 0; i < memWords; i++) begin
      if (i < prog.size()) mem[i] <= prog[i];
      else if (i == dataIdx) mem[i] <= dataWord;
      else mem[i] <= ebreakWord;
    end
  endtask

  task automatic runProgram(input word_t haltPc);
    int cycles;
    @(posedge clk);
    testReset <= 1'b1;
    loadMemory();
    @(posedge clk);
    testReset <= 1'b0;
    @(negedge clk);
    storeAddr.delete();
    storeData.delete();
    pcTrace.delete();
    cycles = 0;
    while (!halt && cycles < runBudget) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    assert (halt)
      else begin
        errorCount++;
        $display("Core did not halt within %0d cycles", runBudget);
      end
    checkValue("pc", haltPc, pc);
  endtask

  task automatic checkIdle();
    checkValue("pc", resetPc, pc);
    checkValue("memWrite", '0, word_t'(memWrite));
    checkValue("halt", '0, word_t'(halt));
    checkValue("illegal", '0, word_t'(illegal));
  endtask

  task automatic checkResetState();
    // A store at the reset vector that reset must hold back
    prog.delete();
    prog.push_back(encS(5'd0, 5'd0, 12'h040));
    dataWord = '0;
    loadMemory();
    @(negedge clk);
    checkIdle();
    prog.delete();
    loadMemory();
    while (reset) @(negedge clk);
    // The ebreak has not retired in the first cycle out of reset
    checkIdle();
  endtask

  task automatic testArithmetic();
    word_t       rnd;
    logic [19:0] upper;
    logic [11:0] immA;
    logic [11:0] immB;
    logic [11:0] immC;
    word_t       x2;
    word_t       x4;
    rnd = $random(seed);
    upper = rnd[31:12];
    immA = rnd[11:0];
    rnd = $random(seed);
    immB = rnd[23:12];
    immC = rnd[11:0];
    x2 = {upper, 12'b0} + sext12(immA);
    x4 = x2 + sext12(immB);
    prog.delete();
    prog.push_back({upper, 5'd1, opLui});
    prog.push_back(encI(opImm, 5'd2, 5'd1, immA));
    prog.push_back(encI(opImm, 5'd3, 5'd0, immB));
    prog.push_back({7'b0, 5'd3, 5'd2, funct3Add, 5'd4, opReg});
    prog.push_back(encS(5'd4, 5'd2, immC));
    prog.push_back(encS(5'd3, 5'd4, 12'h000));
    expAddr.push_back(x2 + sext12(immC));
    expData.push_back(x4);
    expAddr.push_back(x4);
    expData.push_back(sext12(immB));
    runProgram(resetPc + 32'd24);
    compareStores();
  endtask

  task automatic testZeroRegister();
    word_t       rnd;
    logic [11:0] immA;
    rnd = $random(seed);
    immA = rnd[11:0] | 12'h001;
    prog.delete();
    prog.push_back(encI(opImm, 5'd0, 5'd0, immA));
    prog.push_back(encS(5'd0, 5'd0, 12'h100));
    expAddr.push_back(32'h0000_0100);
    expData.push_back('0);
    runProgram(resetPc + 32'd8);
    compareStores();
  endtask

  task automatic testLoadStore();
    dataWord = $random(seed);
    prog.delete();
    prog.push_back({20'h80000, 5'd1, opLui});
    prog.push_back(encI(opLoad, 5'd2, 5'd1, 12'h100));
    prog.push_back(encS(5'd2, 5'd1, 12'h180));
    expAddr.push_back(32'h8000_0180);
    expData.push_back(dataWord);
    runProgram(resetPc + 32'd12);
    compareStores();
  endtask

  task automatic testControlFlow();
    word_t jalTarget;
    word_t jalrTarget;
    word_t expPc [$];
    jalTarget = resetPc + 32'd4 + 32'd12;
    // Odd jalr target with bit 0 dropped
    jalrTarget = (resetPc + sext12(12'h021)) & ~32'h1;
    prog.delete();
    prog.push_back({20'h0, 5'd1, opAuipc});
    prog.push_back(encJal(5'd2, 21'd12));
    repeat (2) prog.push_back(ebreakWord);
    prog.push_back(encI(opJalr, 5'd3, 5'd1, 12'h021));
    repeat (3) prog.push_back(ebreakWord);
    prog.push_back(encS(5'd2, 5'd1, 12'h100));
    prog.push_back(encS(5'd3, 5'd1, 12'h104));
    expAddr.push_back(resetPc + 32'h100);
    expData.push_back(resetPc + 32'd8);
    expAddr.push_back(resetPc + 32'h104);
    expData.push_back(jalTarget + 32'd4);
    expPc = '{resetPc, resetPc + 32'd4, jalTarget, jalrTarget,
              jalrTarget + 32'd4, jalrTarget + 32'd8};
    runProgram(jalrTarget + 32'd8);
    compareStores();
    compareQueue("pc", expPc, pcTrace);
  endtask

  task automatic testHalt();
    prog.delete();
    prog.push_back(encI(opImm, 5'd1, 5'd0, 12'h05a));
    prog.push_back(ebreakWord);
    prog.push_back(encS(5'd1, 5'd0, 12'h040));
    prog.push_back(encS(5'd1, 5'd0, 12'h044));
    runProgram(resetPc + 32'd4);
    repeat (10) begin
      @(negedge clk);
      checkValue("halt", 32'd1, word_t'(halt));
      checkValue("pc", resetPc + 32'd4, pc);
    end
    // Stores behind the ebreak must never retire
    compareStores();
  endtask

  initial begin
    seed = 32'h1290_7241;
    errorCount = 0;
    checkCount = 0;
    testReset <= 1'b0;
    for (int i = 0; i < memWords; i++) begin
      mem[i] <= ebreakWord;
    end
    checkResetState();
    testArithmetic();
    testZeroRegister();
    testLoadStore();
    testControlFlow();
    testHalt();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * periodNs);
    $display("Watchdog expired after %0d cycles before the tests completed", watchdogCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verilog.f
src/coreDefs.sv
src/ctrlIf.sv
src/instDecoder.sv
src/immGen.sv
src/registerFile.sv
src/executeUnit.sv
src/pcUnit.sv
src/rvCore.sv
sim/clockGen.sv
sim/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
